//--- sdi_consts.svh
`ifndef SDI_CONSTS_SVH
`define SDI_CONSTS_SVH

// Clocks per UART bit
`define SDI_BAUD_DIV 16

// Received-byte queue depth
// Holds three full command frames
`define SDI_RX_DEPTH 16

// Response queue depth
// Only one command is ever in flight
`define SDI_RSP_DEPTH 2

// Command frame is cmd byte plus 32-bit word, MSB first
// Response frame is status byte plus 32-bit word
`define SDI_FRAME_BYTES 5

// Status byte codes in the response frame
`define SDI_STATUS_OK 8'h00
`define SDI_STATUS_ERR 8'h01

`endif

//--- sdi_link_pkg.sv
package sdi_link_pkg;

	// One UART character
	typedef logic [7:0] sdi_byte_t;

	// Framer control states
	typedef enum logic [2:0] {
		// Waiting for the first byte of a frame
		fr_idle,
		// Popping the five command bytes
		fr_collect,
		// Request held on the common interface
		fr_issue,
		// Command accepted, response not back yet
		fr_wait_rsp,
		// Serializing status and result word
		fr_send
	} framer_state_t;

	// Shifter states, shared by receiver and transmitter
	typedef enum logic [1:0] {
		phy_idle,
		phy_start,
		phy_data,
		phy_stop
	} phy_state_t;

endpackage

//--- sdi_cmd_pkg.sv
package sdi_cmd_pkg;

	// Command code
	// Bit 7 set makes the target report an error
	typedef logic [7:0] sdi_cmd_t;

	// Command argument and result word
	typedef logic [31:0] sdi_word_t;

	// Response as queued toward the framer
	typedef struct packed {
		// Target flagged the command as failed
		logic error;
		// Result word
		sdi_word_t data;
	} sdi_rsp_t;

	// Status byte width for the serial frame
	localparam int SDI_STATUS_W = 8;

	// Bytes carried by one data word
	localparam int SDI_WORD_BYTES = $bits(sdi_word_t) / 8;

	// Response entry width, error bit plus word
	localparam int SDI_RSP_W = $bits(sdi_rsp_t);

endpackage

//--- sdi_baud_timer.sv
`include "sdi_consts.svh"

module sdi_baud_timer (
	input logic clock,
	input logic reset,
	input logic run,
	output logic sample,
	output logic bit_end
);

	localparam int CW = $clog2(`SDI_BAUD_DIV);
	localparam logic [CW-1:0] LAST = CW'(`SDI_BAUD_DIV - 1);
	localparam logic [CW-1:0] HALF = CW'(`SDI_BAUD_DIV / 2);

	// Position inside the current bit period
	logic [CW-1:0] count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (!run) begin
			// Idle shifter keeps the phase at zero
			count <= '0;
		end else if (count == LAST) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Middle of the bit, where the line is read
	assign sample = run && (count == HALF);

	// Last clock of the bit period
	// Transmitter moves to the next bit here
	assign bit_end = run && (count == LAST);

endmodule

//--- sdi_uart_phy.sv
module sdi_uart_phy
	import sdi_link_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic uart_rxd,
	output logic uart_txd,
	output logic rx_push,
	output sdi_byte_t rx_byte,
	input logic tx_start,
	input sdi_byte_t tx_byte,
	output logic tx_busy
);

	// Receive side
	logic rxd_meta;
	logic rxd_sync;
	phy_state_t rx_state;
	logic [2:0] rx_bits;
	sdi_byte_t rx_shift;
	logic rx_run;
	logic rx_sample;

	// Transmit side
	phy_state_t tx_state;
	logic [2:0] tx_bits;
	sdi_byte_t tx_shift;
	logic tx_run;
	logic tx_bit_end;

	assign rx_run = (rx_state != phy_idle);
	assign tx_run = (tx_state != phy_idle);

	// Receiver only needs mid-bit points
	sdi_baud_timer rx_timer (
		.clock(clock),
		.reset(reset),
		.run(rx_run),
		.sample(rx_sample),
		.bit_end()
	);

	// Transmitter only needs bit boundaries
	sdi_baud_timer tx_timer (
		.clock(clock),
		.reset(reset),
		.run(tx_run),
		.sample(),
		.bit_end(tx_bit_end)
	);

	// Two-flop synchronizer, line idles high
	always_ff @(posedge clock) begin
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= uart_rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rx_state <= phy_idle;
			rx_bits <= '0;
		end else begin
			case (rx_state)
				phy_idle: begin
					// Falling edge of the start bit
					if (!rxd_sync) begin
						rx_state <= phy_start;
					end
				end
				phy_start: begin
					// Glitch shorter than half a bit goes back to idle
					if (rx_sample) begin
						rx_state <= rxd_sync ? phy_idle : phy_data;
						rx_bits <= '0;
					end
				end
				phy_data: begin
					if (rx_sample) begin
						rx_bits <= rx_bits + 1'b1;
						if (rx_bits == 3'd7) begin
							rx_state <= phy_stop;
						end
					end
				end
				default: begin
					// Back to idle mid stop bit to catch the next start edge
					if (rx_sample) begin
						rx_state <= phy_idle;
					end
				end
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clock) begin
		if (rx_state == phy_data && rx_sample) begin
			rx_shift <= {rxd_sync, rx_shift[7:1]};
		end
	end

	// Framing error drops the byte
	assign rx_push = (rx_state == phy_stop) && rx_sample && rxd_sync;
	assign rx_byte = rx_shift;

	always_ff @(posedge clock) begin
		if (reset) begin
			tx_state <= phy_idle;
			tx_bits <= '0;
		end else begin
			case (tx_state)
				phy_idle: begin
					if (tx_start) begin
						tx_state <= phy_start;
					end
				end
				phy_start: begin
					if (tx_bit_end) begin
						tx_state <= phy_data;
						tx_bits <= '0;
					end
				end
				phy_data: begin
					if (tx_bit_end) begin
						tx_bits <= tx_bits + 1'b1;
						if (tx_bits == 3'd7) begin
							tx_state <= phy_stop;
						end
					end
				end
				default: begin
					if (tx_bit_end) begin
						tx_state <= phy_idle;
					end
				end
			endcase
		end
	end

	// Load on start, shift out one bit per period
	always_ff @(posedge clock) begin
		if (tx_state == phy_idle && tx_start) begin
			tx_shift <= tx_byte;
		end else if (tx_state == phy_data && tx_bit_end) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end
	end

	// Idle and stop both drive a mark
	assign uart_txd = (tx_state == phy_start) ? 1'b0 :
		(tx_state == phy_data) ? tx_shift[0] : 1'b1;

	assign tx_busy = tx_run;

endmodule

//--- sdi_sync_fifo.sv
module sdi_sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clock,
	input logic reset,
	input logic push,
	input payload_t wdata,
	input logic pop,
	output payload_t rdata,
	output logic empty,
	output logic full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	// Overflow and underflow are ignored
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Head entry visible without a pop
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));

endmodule

//--- sdi_uart_framer.sv
`include "sdi_consts.svh"

module sdi_uart_framer
	import sdi_link_pkg::*;
	import sdi_cmd_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic rx_empty,
	input sdi_byte_t rx_byte,
	output logic rx_pop,
	output logic u_req,
	output sdi_cmd_t u_cmd,
	output sdi_word_t u_data,
	input logic u_busy,
	input logic rsp_empty,
	input sdi_rsp_t rsp,
	output logic rsp_pop,
	output logic tx_start,
	output sdi_byte_t tx_byte,
	input logic tx_busy
);

	localparam logic [2:0] LAST_BYTE = 3'(`SDI_FRAME_BYTES - 1);

	framer_state_t state;
	// Position in the command or response frame
	logic [2:0] byte_idx;
	sdi_cmd_t cmd_reg;
	sdi_word_t data_reg;
	sdi_byte_t status;

	assign rx_pop = (state == fr_collect) && !rx_empty;
	assign u_req = (state == fr_issue);
	assign u_cmd = cmd_reg;
	assign u_data = data_reg;

	// Next byte goes out as soon as the shifter is free
	assign tx_start = (state == fr_send) && !tx_busy;

	// Head response stays in the queue until its last byte starts
	assign rsp_pop = tx_start && (byte_idx == LAST_BYTE);

	assign status = rsp.error ? `SDI_STATUS_ERR : `SDI_STATUS_OK;

	// Status first, then result MSB first
	always_comb begin
		case (byte_idx)
			3'd0: tx_byte = status;
			3'd1: tx_byte = rsp.data[31:24];
			3'd2: tx_byte = rsp.data[23:16];
			3'd3: tx_byte = rsp.data[15:8];
			default: tx_byte = rsp.data[7:0];
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fr_idle;
			byte_idx <= '0;
		end else begin
			case (state)
				fr_idle: begin
					byte_idx <= '0;
					if (!rx_empty) begin
						state <= fr_collect;
					end
				end
				fr_collect: begin
					if (rx_pop) begin
						byte_idx <= byte_idx + 1'b1;
						// Request goes up the cycle after the fifth pop
						if (byte_idx == LAST_BYTE) begin
							state <= fr_issue;
						end
					end
				end
				fr_issue: begin
					// Held until the target takes it
					if (!u_busy) begin
						state <= fr_wait_rsp;
					end
				end
				fr_wait_rsp: begin
					byte_idx <= '0;
					if (!rsp_empty) begin
						state <= fr_send;
					end
				end
				default: begin
					if (tx_start) begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == LAST_BYTE) begin
							state <= fr_idle;
						end
					end
				end
			endcase
		end
	end

	// First byte is the command, the rest fill the word MSB first
	always_ff @(posedge clock) begin
		if (rx_pop) begin
			if (byte_idx == 3'd0) begin
				cmd_reg <= rx_byte;
			end else begin
				data_reg <= {data_reg[23:0], rx_byte};
			end
		end
	end

endmodule

//--- sdi_port_select.sv
module sdi_port_select
	import sdi_cmd_pkg::*;
(
	input logic clock,
	input logic reset,
	// 0 picks UART, 1 picks the parallel port
	input logic if_select,
	input logic u_req,
	input sdi_cmd_t u_cmd,
	input sdi_word_t u_data,
	output logic u_busy,
	output logic rsp_push,
	output sdi_rsp_t rsp_wdata,
	input logic rsp_full,
	input logic para_req,
	output logic para_busy,
	input sdi_cmd_t para_cmd,
	input sdi_word_t para_data,
	output logic para_valid,
	input logic para_resp_busy,
	output logic para_error,
	output sdi_word_t para_rdata,
	output logic com_req,
	input logic com_busy,
	output sdi_cmd_t com_cmd,
	output sdi_word_t com_data,
	input logic com_valid,
	output logic com_resp_busy,
	input logic com_error,
	input sdi_word_t com_rdata
);

	// High when the parallel port holds the interface
	logic owner;
	logic outstanding;
	logic cmd_accept;
	logic rsp_done;
	logic owner_busy;

	assign cmd_accept = com_req && !com_busy;
	assign rsp_done = com_valid && !com_resp_busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			owner <= 1'b0;
			outstanding <= 1'b0;
		end else begin
			// Choice frozen from acceptance until the response is gone
			if (!outstanding && !cmd_accept) begin
				owner <= if_select;
			end
			if (cmd_accept) begin
				outstanding <= 1'b1;
			end else if (rsp_done) begin
				outstanding <= 1'b0;
			end
		end
	end

	// One command in flight, a second request waits
	assign com_req = !outstanding && (owner ? para_req : u_req);
	assign com_cmd = owner ? para_cmd : u_cmd;
	assign com_data = owner ? para_data : u_data;

	// Port without ownership always sees busy
	assign owner_busy = com_busy || outstanding;
	assign para_busy = owner ? owner_busy : 1'b1;
	assign u_busy = owner ? 1'b1 : owner_busy;

	assign para_valid = owner && com_valid;
	assign para_error = com_error;
	assign para_rdata = com_rdata;

	// UART responses land in the queue, full queue stalls the target
	assign rsp_push = !owner && com_valid && !rsp_full;
	assign rsp_wdata = '{error: com_error, data: com_rdata};
	assign com_resp_busy = owner ? para_resp_busy : rsp_full;

endmodule

//--- sdi_interface_control.sv
`include "sdi_consts.svh"

module sdi_interface_control
	import sdi_link_pkg::*;
	import sdi_cmd_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic if_select,
	input logic uart_rxd,
	output logic uart_txd,
	input logic para_req,
	output logic para_busy,
	input sdi_cmd_t para_cmd,
	input sdi_word_t para_data,
	output logic para_valid,
	input logic para_resp_busy,
	output logic para_error,
	output sdi_word_t para_rdata,
	output logic com_req,
	input logic com_busy,
	output sdi_cmd_t com_cmd,
	output sdi_word_t com_data,
	input logic com_valid,
	output logic com_resp_busy,
	input logic com_error,
	input sdi_word_t com_rdata
);

	// PHY to receive queue
	logic rx_push;
	sdi_byte_t rx_byte;

	// Receive queue to framer
	logic rx_pop;
	logic rx_empty;
	sdi_byte_t rx_head;

	// Framer to transmitter
	logic tx_start;
	sdi_byte_t tx_byte;
	logic tx_busy;

	// Framer request toward port select
	logic u_req;
	sdi_cmd_t u_cmd;
	sdi_word_t u_data;
	logic u_busy;

	// Response queue between port select and framer
	logic rsp_push;
	sdi_rsp_t rsp_wdata;
	logic rsp_full;
	logic rsp_pop;
	logic rsp_empty;
	sdi_rsp_t rsp_head;

	sdi_uart_phy u_phy (
		.clock(clock),
		.reset(reset),
		.uart_rxd(uart_rxd),
		.uart_txd(uart_txd),
		.rx_push(rx_push),
		.rx_byte(rx_byte),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy)
	);

	// Bytes beyond the depth are lost
	sdi_sync_fifo #(
		.payload_t(sdi_byte_t),
		.DEPTH(`SDI_RX_DEPTH)
	) rx_fifo (
		.clock(clock),
		.reset(reset),
		.push(rx_push),
		.wdata(rx_byte),
		.pop(rx_pop),
		.rdata(rx_head),
		.empty(rx_empty),
		.full()
	);

	sdi_sync_fifo #(
		.payload_t(sdi_rsp_t),
		.DEPTH(`SDI_RSP_DEPTH)
	) rsp_fifo (
		.clock(clock),
		.reset(reset),
		.push(rsp_push),
		.wdata(rsp_wdata),
		.pop(rsp_pop),
		.rdata(rsp_head),
		.empty(rsp_empty),
		.full(rsp_full)
	);

	sdi_uart_framer u_framer (
		.clock(clock),
		.reset(reset),
		.rx_empty(rx_empty),
		.rx_byte(rx_head),
		.rx_pop(rx_pop),
		.u_req(u_req),
		.u_cmd(u_cmd),
		.u_data(u_data),
		.u_busy(u_busy),
		.rsp_empty(rsp_empty),
		.rsp(rsp_head),
		.rsp_pop(rsp_pop),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy)
	);

	sdi_port_select u_select (
		.clock(clock),
		.reset(reset),
		.if_select(if_select),
		.u_req(u_req),
		.u_cmd(u_cmd),
		.u_data(u_data),
		.u_busy(u_busy),
		.rsp_push(rsp_push),
		.rsp_wdata(rsp_wdata),
		.rsp_full(rsp_full),
		.para_req(para_req),
		.para_busy(para_busy),
		.para_cmd(para_cmd),
		.para_data(para_data),
		.para_valid(para_valid),
		.para_resp_busy(para_resp_busy),
		.para_error(para_error),
		.para_rdata(para_rdata),
		.com_req(com_req),
		.com_busy(com_busy),
		.com_cmd(com_cmd),
		.com_data(com_data),
		.com_valid(com_valid),
		.com_resp_busy(com_resp_busy),
		.com_error(com_error),
		.com_rdata(com_rdata)
	);

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// Free-running clock
	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// Reset released on a rising edge, like any other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- tb_sdi_interface_control.sv
`include "sdi_consts.svh"

module tb_sdi_interface_control;
	timeunit 1ns;
	timeprecision 100ps;

	// Entry layout is mode, cmd, data
	localparam int NUM_TESTS = 11;
	localparam logic [1:0] MODE_PARA = 2'd0;
	localparam logic [1:0] MODE_UART = 2'd1;
	localparam logic [1:0] MODE_TOGGLE = 2'd2;
	// This entry and the next one go out back to back
	localparam logic [1:0] MODE_PAIR = 2'd3;
	// Ten UART bytes per entry, 20 ns clock, 50% margin
	localparam int WATCHDOG_NS = NUM_TESTS * 10 * 160 * 20 * 3 / 2;

	logic clock;
	logic reset;
	logic if_select;
	logic uart_rxd;
	logic uart_txd;
	logic para_req;
	logic para_busy;
	logic [7:0] para_cmd;
	logic [31:0] para_data;
	logic para_valid;
	logic para_resp_busy;
	logic para_error;
	logic [31:0] para_rdata;
	logic com_req;
	logic com_busy;
	logic [7:0] com_cmd;
	logic [31:0] com_data;
	logic com_valid;
	logic com_resp_busy;
	logic com_error;
	logic [31:0] com_rdata;

	logic [41:0] tests [NUM_TESTS];
	int error_count;
	int pass_count;
	int fail_count;
	logic uart_active;
	logic [31:0] lcg_state = 32'hb7dbac88;
	// Commands as the target model took them
	logic [7:0] acc_cmd_q [$];
	logic [31:0] acc_data_q [$];
	event cmd_taken;

	tb_clock_gen #(
		.PERIOD_NS(20),
		.RESET_CYCLES(16)
	) clock_gen (
		.clock(clock),
		.reset(reset)
	);

	sdi_interface_control DUT (
		.clock(clock),
		.reset(reset),
		.if_select(if_select),
		.uart_rxd(uart_rxd),
		.uart_txd(uart_txd),
		.para_req(para_req),
		.para_busy(para_busy),
		.para_cmd(para_cmd),
		.para_data(para_data),
		.para_valid(para_valid),
		.para_resp_busy(para_resp_busy),
		.para_error(para_error),
		.para_rdata(para_rdata),
		.com_req(com_req),
		.com_busy(com_busy),
		.com_cmd(com_cmd),
		.com_data(com_data),
		.com_valid(com_valid),
		.com_resp_busy(com_resp_busy),
		.com_error(com_error),
		.com_rdata(com_rdata)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s is %h, expected %h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic load_table();
		tests[0] = {MODE_PARA, 8'h12, 32'h0000_00ff};
		// Bit 7 of the command marks an error response
		tests[1] = {MODE_PARA, 8'h85, 32'hdead_beef};
		tests[2] = {MODE_UART, 8'h21, 32'h1234_5678};
		tests[3] = {MODE_UART, 8'h9c, 32'hcafe_f00d};
		tests[4] = {MODE_PAIR, 8'h03, 32'h0bad_cafe};
		tests[5] = {MODE_UART, 8'h44, 32'hffff_0000};
		tests[6] = {MODE_TOGGLE, 8'h5a, 32'h8765_4321};
		tests[7] = {MODE_PARA, 8'h7f, 32'h0000_0001};
		tests[8] = {MODE_UART, 8'h80, 32'h0000_0000};
		tests[9] = {MODE_PAIR, 8'h11, 32'h1111_1111};
		tests[10] = {MODE_UART, 8'hfe, 32'h2468_ace0};
	endtask

	task automatic report_test(input int number, input string name, input int errors_before);
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %0d %s: ok", number, name);
		end else begin
			fail_count++;
			$display("test %0d %s: FAILED", number, name);
		end
	endtask

	// Target side of the common interface
	// Random busy before acceptance, short random wait before the response
	task automatic serve_command();
		logic [31:0] rnd;
		int delay;
		logic [7:0] cmd;
		logic [31:0] data;
		rnd = lcg_next();
		delay = rnd[18:16];
		repeat (delay) @(posedge clock);
		com_busy <= 1'b0;
		@(posedge clock);
		if (!com_req) begin
			$display("com_req dropped before the target accepted the command");
			error_count++;
		end
		cmd = com_cmd;
		data = com_data;
		acc_cmd_q.push_back(cmd);
		acc_data_q.push_back(data);
		-> cmd_taken;
		com_busy <= 1'b1;
		rnd = lcg_next();
		delay = 2 + rnd[17:16];
		repeat (delay) @(posedge clock);
		com_valid <= 1'b1;
		com_error <= cmd[7];
		com_rdata <= data ^ {4{cmd}};
		do @(posedge clock); while (com_resp_busy);
		// Parallel port must stay locked out of a UART transaction
		if (uart_active) begin
			check_value("para_valid", para_valid, 32'd0);
			check_value("para_busy", para_busy, 32'd1);
		end
		com_valid <= 1'b0;
	endtask

	initial begin
		forever begin
			@(posedge clock);
			if (!reset && com_req) begin
				serve_command();
			end
		end
	end

	task automatic check_accepted(input logic [7:0] cmd, input logic [31:0] data);
		if (acc_cmd_q.size() == 0) begin
			$display("command %h never reached the common interface", cmd);
			error_count++;
		end else begin
			check_value("com_cmd", acc_cmd_q.pop_front(), cmd);
			check_value("com_data", acc_data_q.pop_front(), data);
		end
	endtask

	// 8N1, LSB first, one bit per baud period
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		int i;
		frame = {1'b1, value, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clock);
			uart_rxd <= frame[i];
			repeat (`SDI_BAUD_DIV - 1) @(posedge clock);
		end
	endtask

	task automatic send_frame(input logic [41:0] entry);
		send_byte(entry[39:32]);
		send_byte(entry[31:24]);
		send_byte(entry[23:16]);
		send_byte(entry[15:8]);
		send_byte(entry[7:0]);
	endtask

	// Decode one byte off uart_txd at mid-bit
	task automatic recv_byte(output logic [7:0] value);
		int i;
		do @(posedge clock); while (uart_txd);
		repeat (`SDI_BAUD_DIV / 2) @(posedge clock);
		if (uart_txd) begin
			$display("start bit on uart_txd ended early");
			error_count++;
		end
		for (i = 0; i < 8; i++) begin
			repeat (`SDI_BAUD_DIV) @(posedge clock);
			value[i] = uart_txd;
		end
		repeat (`SDI_BAUD_DIV) @(posedge clock);
		if (!uart_txd) begin
			$display("stop bit on uart_txd was low");
			error_count++;
		end
	endtask

	task automatic run_para(input int idx);
		logic [7:0] cmd;
		logic [31:0] data;
		cmd = tests[idx][39:32];
		data = tests[idx][31:0];
		@(posedge clock);
		if_select <= 1'b1;
		repeat (2) @(posedge clock);
		para_cmd <= cmd;
		para_data <= data;
		para_req <= 1'b1;
		// Host stalls the response at first
		para_resp_busy <= 1'b1;
		// Accepted on the edge where busy reads low
		do @(posedge clock); while (para_busy);
		para_req <= 1'b0;
		do @(posedge clock); while (!para_valid);
		// Stalled response stays up on the port
		repeat (2) @(posedge clock);
		check_value("com_resp_busy", com_resp_busy, 32'd1);
		check_value("para_valid", para_valid, 32'd1);
		para_resp_busy <= 1'b0;
		@(posedge clock);
		check_value("para_valid", para_valid, 32'd1);
		check_value("para_rdata", para_rdata, data ^ {4{cmd}});
		check_value("para_error", para_error, cmd[7]);
		check_accepted(cmd, data);
	endtask

	task automatic run_uart(input int first, input int count, input bit toggle);
		int ks;
		int kr;
		int b;
		logic [7:0] status;
		logic [7:0] rx_val;
		logic [31:0] word;
		logic [7:0] cmd;
		@(posedge clock);
		if_select <= 1'b0;
		repeat (2) @(posedge clock);
		uart_active = 1'b1;
		fork
			begin
				for (ks = 0; ks < count; ks++) begin
					send_frame(tests[first + ks]);
				end
			end
			begin
				for (kr = 0; kr < count; kr++) begin
					recv_byte(status);
					word = '0;
					for (b = 0; b < 4; b++) begin
						recv_byte(rx_val);
						word = {word[23:0], rx_val};
					end
					cmd = tests[first + kr][39:32];
					check_value("uart status", status,
						cmd[7] ? `SDI_STATUS_ERR : `SDI_STATUS_OK);
					check_value("uart result", word, tests[first + kr][31:0] ^ {4{cmd}});
				end
			end
			begin
				// Flip the select while the UART command is in flight
				if (toggle) begin
					@(cmd_taken);
					@(posedge clock);
					if_select <= 1'b1;
				end
			end
		join
		uart_active = 1'b0;
		for (kr = 0; kr < count; kr++) begin
			check_accepted(tests[first + kr][39:32], tests[first + kr][31:0]);
		end
		if (toggle) begin
			@(posedge clock);
			if_select <= 1'b0;
		end
	endtask

	initial begin
		int idx;
		int errors_before;
		logic [1:0] mode;
		if_select = 1'b0;
		uart_rxd = 1'b1;
		para_req = 1'b0;
		para_cmd = '0;
		para_data = '0;
		para_resp_busy = 1'b0;
		// Target idles busy and drops it to accept
		com_busy = 1'b1;
		com_valid = 1'b0;
		com_error = 1'b0;
		com_rdata = '0;
		uart_active = 1'b0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		load_table();
		do @(posedge clock); while (reset);
		errors_before = error_count;
		check_value("uart_txd", uart_txd, 32'd1);
		check_value("com_req", com_req, 32'd0);
		check_value("para_valid", para_valid, 32'd0);
		report_test(0, "reset state", errors_before);
		idx = 0;
		while (idx < NUM_TESTS) begin
			errors_before = error_count;
			mode = tests[idx][41:40];
			if (mode == MODE_PARA) begin
				run_para(idx);
				report_test(idx + 1, "parallel", errors_before);
				idx += 1;
			end else if (mode == MODE_PAIR) begin
				run_uart(idx, 2, 1'b0);
				report_test(idx + 1, "uart back to back", errors_before);
				report_test(idx + 2, "uart back to back", errors_before);
				idx += 2;
			end else if (mode == MODE_TOGGLE) begin
				run_uart(idx, 1, 1'b1);
				report_test(idx + 1, "uart owner lock", errors_before);
				idx += 1;
			end else begin
				run_uart(idx, 1, 1'b0);
				report_test(idx + 1, "uart", errors_before);
				idx += 1;
			end
			repeat (4) @(posedge clock);
		end
		$display("%0d tests run, %0d passed, %0d failed, %0d check errors",
			pass_count + fail_count, pass_count, fail_count, error_count);
		if (error_count == 0 && fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Stuck handshake or silent uart_txd ends here
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the DUT stopped responding", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- sdi_interface_control.f
+incdir+.
sdi_link_pkg.sv
sdi_cmd_pkg.sv
sdi_baud_timer.sv
sdi_uart_phy.sv
sdi_sync_fifo.sv
sdi_uart_framer.sv
sdi_port_select.sv
sdi_interface_control.sv
tb_clock_gen.sv
tb_sdi_interface_control.sv
